/* delqa_bus.f */
+incdir+rtl
+incdir+tests
rtl/delqa_pkg.sv
rtl/lb_decoder.sv
rtl/rx_buffer.sv
rtl/tx_buffer.sv
rtl/bdl_regs.sv
rtl/dma_port.sv
rtl/delqa_bus.sv
tests/tb_delqa_bus.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the DELQA core testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_delqa_bus -f delqa_bus.f -o sim_delqa_bus

# the simulator exits nonzero on an error, the log is checked below
status=0
./obj_dir/sim_delqa_bus > "$LOG" 2>&1 || status=$?
cat "$LOG"
if grep -qF '*** FAILED ***' "$LOG" || [ "$status" -ne 0 ]; then
	echo "simulation failed, see $LOG"
	exit 1
fi
echo "simulation passed"

/* tests/tb_tasks.svh */
/*
  bus drivers, check helpers and directed tests, included in tb_delqa_bus
  each task is entered and left 1 ns after a rising clock edge
*/

// byte addresses from the region map, idx is the word index in the region
function automatic logic [`DQ_ADR_W-1:0] rx_byte_adr(input logic [`DQ_RXBUF_AW-1:0] idx);
	return `DQ_RXBUF_BASE | {4'b0, idx, 1'b0};
endfunction

function automatic logic [`DQ_ADR_W-1:0] tx_byte_adr(input logic [`DQ_TXBUF_AW-1:0] idx);
	return `DQ_TXBUF_BASE | {5'b0, idx, 1'b0};
endfunction

function automatic logic [`DQ_ADR_W-1:0] bdl_byte_adr(input logic [`DQ_BDL_AW-1:0] idx);
	return `DQ_BDL_BASE | {12'b0, idx, 1'b0};
endfunction

function automatic logic [`DQ_DATA_W-1:0] rand_word();
	logic [31:0] r;
	r = $random(seed);
	return r[`DQ_DATA_W-1:0];
endfunction

task automatic check_word(input string what, input logic [`DQ_DATA_W-1:0] got,
		input logic [`DQ_DATA_W-1:0] exp);
	assert (got === exp) else
		abort_run($sformatf("ERROR at %0t: %s read %h, expected %h", $time, what, got, exp));
endtask

//******************************
// bus drivers
//******************************
task automatic lb_cycle(input logic we, input logic [1:0] sel,
		input logic [`DQ_ADR_W-1:0] adr, input logic [`DQ_DATA_W-1:0] wdat,
		output logic [`DQ_DATA_W-1:0] rdat);
	int waited;
	waited   = 0;
	wb_cyc_i = 1'b1;
	wb_stb_i = 1'b1;
	wb_we_i  = we;
	wb_sel_i = sel;
	wb_adr_i = adr;
	wb_dat_i = wdat;
	do begin
		@(posedge lwb_clkp);
		#1;
		waited++;
	end while (!wb_ack_o && waited < ACK_TIMEOUT);
	if (!wb_ack_o)
		abort_run($sformatf("no local-bus ack within %0d cycles at address %o",
			ACK_TIMEOUT, adr));
	assert (waited == 1) else
		abort_run($sformatf("ERROR at %0t: local-bus ack after %0d cycles, expected 1",
			$time, waited));
	rdat     = wb_dat_o;	// valid with ack
	wb_cyc_i = 1'b0;
	wb_stb_i = 1'b0;
	wb_we_i  = 1'b0;
	@(posedge lwb_clkp);	// one idle cycle between requests
	#1;
	assert (!wb_ack_o) else
		abort_run($sformatf("ERROR at %0t: local-bus ack longer than one cycle", $time));
endtask

task automatic dma_cycle(input logic we, input logic [`DQ_ADR_W-2:0] adr,
		input logic [`DQ_DATA_W-1:0] wdat, output logic [`DQ_DATA_W-1:0] rdat);
	int waited;
	waited    = 0;
	dma_stb_i = 1'b1;
	dma_we_i  = we;
	dma_adr_i = adr;
	dma_dat_i = wdat;
	do begin
		@(posedge lwb_clkp);
		#1;
		waited++;
	end while (!dma_ack_o && waited < ACK_TIMEOUT);
	if (!dma_ack_o)
		abort_run($sformatf("no DMA ack within %0d cycles at word address %h",
			ACK_TIMEOUT, adr));
	assert (waited == 1) else
		abort_run($sformatf("ERROR at %0t: DMA ack after %0d cycles, expected 1",
			$time, waited));
	rdat      = dma_dat_o;
	dma_stb_i = 1'b0;
	dma_we_i  = 1'b0;
	@(posedge lwb_clkp);
	#1;
	assert (!dma_ack_o) else
		abort_run($sformatf("ERROR at %0t: DMA ack longer than one cycle", $time));
endtask

task automatic lb_write(input logic [`DQ_ADR_W-1:0] adr, input logic [`DQ_DATA_W-1:0] dat,
		input logic [1:0] sel);
	logic [`DQ_DATA_W-1:0] unused;
	lb_cycle(1'b1, sel, adr, dat, unused);
endtask

task automatic lb_read(input logic [`DQ_ADR_W-1:0] adr, output logic [`DQ_DATA_W-1:0] dat);
	lb_cycle(1'b0, 2'b11, adr, '0, dat);
endtask

//******************************
// directed tests
//******************************
task automatic test_bdl_reset_and_bytes();
	logic [`DQ_DATA_W-1:0] got, full, low;
	for (int i = 0; i < 8; i++) begin
		lb_read(bdl_byte_adr(i[2:0]), got);
		check_word($sformatf("BDL %0d after reset", i), got, '0);
	end
	full = rand_word();
	low  = rand_word();
	lb_write(bdl_byte_adr(3'd2), full, 2'b11);
	lb_write(bdl_byte_adr(3'd2), low, 2'b01);	// low byte only
	lb_read(bdl_byte_adr(3'd2), got);
	check_word("BDL 2 after low-byte write", got, {full[15:8], low[7:0]});
endtask

task automatic test_lb_buffers();
	logic [`DQ_RXBUF_AW-1:0] rx_idx [4];
	logic [`DQ_TXBUF_AW-1:0] tx_idx [4];
	logic [`DQ_DATA_W-1:0]   rx_dat [4];
	logic [`DQ_DATA_W-1:0]   tx_dat [4];
	logic [`DQ_DATA_W-1:0]   got;
	rx_idx = '{11'd0, 11'd1, 11'd1000, 11'd2047};	// both ends of each buffer
	tx_idx = '{10'd0, 10'd5, 10'd512, 10'd1023};
	for (int k = 0; k < 4; k++) begin
		rx_dat[k] = rand_word();
		tx_dat[k] = rand_word();
		lb_write(rx_byte_adr(rx_idx[k]), rx_dat[k], 2'b11);
		lb_write(tx_byte_adr(tx_idx[k]), tx_dat[k], 2'b11);
	end
	for (int k = 0; k < 4; k++) begin
		lb_read(rx_byte_adr(rx_idx[k]), got);
		check_word($sformatf("rx buffer word %0d", rx_idx[k]), got, rx_dat[k]);
		lb_read(tx_byte_adr(tx_idx[k]), got);
		check_word($sformatf("tx buffer word %0d", tx_idx[k]), got, tx_dat[k]);
	end
endtask

task automatic test_eth_rx_to_dma();
	logic [`DQ_RXBUF_AW-1:0] idx [3];
	logic [`DQ_DATA_W-1:0]   dat [3];
	logic [`DQ_ADR_W-1:0]    adr;
	logic [`DQ_DATA_W-1:0]   got;
	idx = '{11'd4, 11'd700, 11'd2046};
	for (int k = 0; k < 3; k++) begin
		dat[k]       = rand_word();
		eth_rx_we_i  = 1'b1;	// one-cycle write
		eth_rx_adr_i = idx[k];
		eth_rx_dat_i = dat[k];
		@(posedge lwb_clkp);
		#1;
	end
	eth_rx_we_i = 1'b0;	// port B free before any DMA read
	for (int k = 0; k < 3; k++) begin
		adr = rx_byte_adr(idx[k]);
		dma_cycle(1'b0, adr[`DQ_ADR_W-1:1], '0, got);
		check_word($sformatf("DMA read of rx word %0d", idx[k]), got, dat[k]);
	end
endtask

task automatic test_dma_tx_to_eth();
	logic [`DQ_TXBUF_AW-1:0] idx [3];
	logic [`DQ_DATA_W-1:0]   dat [3];
	logic [`DQ_ADR_W-1:0]    adr;
	logic [`DQ_DATA_W-1:0]   got;
	idx = '{10'd3, 10'd512, 10'd1023};
	for (int k = 0; k < 3; k++) begin
		dat[k] = rand_word();
		adr    = tx_byte_adr(idx[k]);
		dma_cycle(1'b1, adr[`DQ_ADR_W-1:1], dat[k], got);
	end
	for (int k = 0; k < 3; k++) begin
		eth_tx_adr_i = idx[k];
		@(posedge lwb_clkp);	// word shows one cycle later
		#1;
		check_word($sformatf("Ethernet read of tx word %0d", idx[k]), eth_tx_dat_o, dat[k]);
		lb_read(tx_byte_adr(idx[k]), got);
		check_word($sformatf("local read of tx word %0d", idx[k]), got, dat[k]);
	end
endtask

task automatic test_dma_bdl_and_unmapped();
	logic [`DQ_ADR_W-1:0]  adr;
	logic [`DQ_DATA_W-1:0] dat, got;
	dat = rand_word();
	adr = bdl_byte_adr(3'd5);
	dma_cycle(1'b1, adr[`DQ_ADR_W-1:1], dat, got);
	lb_read(bdl_byte_adr(3'd5), got);
	check_word("BDL 5 after DMA write", got, dat);
	lb_read(16'o030000, got);	// hole above the BDL
	check_word("unmapped address 030000", got, '0);
endtask

/* tests/tb_delqa_bus.sv */
/*
  directed testbench of the DELQA shared-memory core
  inputs change 1 ns after the rising edge, outputs are sampled there too
  the run stops at the first error, every ack wait has its own timeout
*/
`include "delqa_settings.svh"

module tb_delqa_bus;
timeunit 1ns;
timeprecision 100ps;

localparam int ACK_TIMEOUT = 16;	// cycles before an ack wait gives up

logic			lwb_clkp;
logic			wb_rst_i;
logic			wb_cyc_i;
logic			wb_stb_i;
logic			wb_we_i;
logic [1:0]		wb_sel_i;
logic [`DQ_ADR_W-1:0]	wb_adr_i;	// byte address
logic [`DQ_DATA_W-1:0]	wb_dat_i;
logic			wb_ack_o;
logic [`DQ_DATA_W-1:0]	wb_dat_o;
logic			dma_stb_i;
logic [`DQ_ADR_W-2:0]	dma_adr_i;	// word address
logic [`DQ_DATA_W-1:0]	dma_dat_i;
logic			dma_we_i;
logic			dma_ack_o;
logic [`DQ_DATA_W-1:0]	dma_dat_o;
logic			eth_rx_we_i;
logic [`DQ_RXBUF_AW-1:0]	eth_rx_adr_i;
logic [`DQ_DATA_W-1:0]	eth_rx_dat_i;
logic [`DQ_TXBUF_AW-1:0]	eth_tx_adr_i;
logic [`DQ_DATA_W-1:0]	eth_tx_dat_o;
integer			seed;		// $random state

delqa_bus DUT (.*);

always #4 lwb_clkp = ~lwb_clkp;	// 8 ns period

// prints what went wrong, then ends the run
task automatic abort_run(input string line);
	$display("%s", line);
	$display("*** FAILED ***");
	$fatal(1, "simulation stopped at first error");
endtask

`include "tb_tasks.svh"

initial begin
	$timeformat(-9, 1, " ns", 0);
	seed         = 32'he368_4d51;
	lwb_clkp     = 1'b0;
	wb_rst_i     = 1'b1;	// held for 5 cycles
	wb_cyc_i     = 1'b0;
	wb_stb_i     = 1'b0;
	wb_we_i      = 1'b0;
	wb_sel_i     = 2'b00;
	wb_adr_i     = '0;
	wb_dat_i     = '0;
	dma_stb_i    = 1'b0;
	dma_adr_i    = '0;
	dma_dat_i    = '0;
	dma_we_i     = 1'b0;
	eth_rx_we_i  = 1'b0;
	eth_rx_adr_i = '0;
	eth_rx_dat_i = '0;
	eth_tx_adr_i = '0;	// stays put while DMA fills the tx buffer

	repeat (5) @(posedge lwb_clkp);
	#1;
	wb_rst_i = 1'b0;
	assert (!wb_ack_o && !dma_ack_o) else
		abort_run($sformatf("ERROR at %0t: ack high after reset", $time));

	//******************************
	// directed tests
	//******************************
	test_bdl_reset_and_bytes();	// must run first, checks reset values
	test_lb_buffers();
	test_eth_rx_to_dma();
	test_dma_tx_to_eth();
	test_dma_bdl_and_unmapped();

	$display("*** PASSED ***");
	$finish;
end

endmodule

/* rtl/delqa_bus.sv */
/*
  shared-memory core of a DELQA-style controller, single clock lwb_clkp
  Wishbone slave, DMA local port and Ethernet buffer port
  Ethernet writes must not meet DMA reads of the receive buffer, and
  DMA writes must not meet Ethernet reads of the transmit buffer
*/
`include "delqa_settings.svh"

module delqa_bus import delqa_pkg::*; (
	input  logic			lwb_clkp,	// bus clock
	input  logic			wb_rst_i,	// async reset
	// local bus
	input  logic			wb_cyc_i,
	input  logic			wb_stb_i,
	input  logic			wb_we_i,
	input  logic [1:0]		wb_sel_i,
	input  logic [`DQ_ADR_W-1:0]	wb_adr_i,
	input  logic [`DQ_DATA_W-1:0]	wb_dat_i,
	output logic			wb_ack_o,
	output logic [`DQ_DATA_W-1:0]	wb_dat_o,
	// DMA local side
	input  logic			dma_stb_i,
	input  logic [`DQ_ADR_W-2:0]	dma_adr_i,	// word address
	input  logic [`DQ_DATA_W-1:0]	dma_dat_i,
	input  logic			dma_we_i,
	output logic			dma_ack_o,
	output logic [`DQ_DATA_W-1:0]	dma_dat_o,
	// Ethernet buffer side
	input  logic			eth_rx_we_i,
	input  logic [`DQ_RXBUF_AW-1:0]	eth_rx_adr_i,
	input  logic [`DQ_DATA_W-1:0]	eth_rx_dat_i,
	input  logic [`DQ_TXBUF_AW-1:0]	eth_tx_adr_i,
	output logic [`DQ_DATA_W-1:0]	eth_tx_dat_o
);

lb_req_t		lb_req;			// local-bus request to targets
logic			lrxb_sel, ltxb_sel, lbdl_sel;
logic [`DQ_DATA_W-1:0]	lrxb_dat, ltxb_dat, lbdl_dat;
dma_req_t		dma_req;		// bundled DMA request
logic			drxb_rd, dtxb_we, dbdl_sel, dbdl_we;
logic [`DQ_DATA_W-1:0]	drxb_dat, dbdl_dat;

assign dma_req = '{adr: dma_adr_i, dat: dma_dat_i, we: dma_we_i};

lb_decoder u_lb (
	.lwb_clkp(lwb_clkp), .wb_rst_i(wb_rst_i),
	.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
	.wb_sel_i(wb_sel_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
	.wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o), .lb_req_o(lb_req),
	.rxb_sel_o(lrxb_sel), .txb_sel_o(ltxb_sel), .bdl_sel_o(lbdl_sel),
	.rxb_dat_i(lrxb_dat), .txb_dat_i(ltxb_dat), .bdl_dat_i(lbdl_dat)
);

rx_buffer u_rxb (
	.lwb_clkp(lwb_clkp), .lb_req_i(lb_req), .lb_sel_i(lrxb_sel), .lb_dat_o(lrxb_dat),
	.dma_rd_i(drxb_rd), .dma_adr_i(dma_req.adr[`DQ_RXBUF_AW-1:0]), .dma_dat_o(drxb_dat),
	.eth_we_i(eth_rx_we_i), .eth_adr_i(eth_rx_adr_i), .eth_dat_i(eth_rx_dat_i)
);

tx_buffer u_txb (
	.lwb_clkp(lwb_clkp), .lb_req_i(lb_req), .lb_sel_i(ltxb_sel), .lb_dat_o(ltxb_dat),
	.dma_we_i(dtxb_we), .dma_adr_i(dma_req.adr[`DQ_TXBUF_AW-1:0]), .dma_dat_i(dma_req.dat),
	.eth_adr_i(eth_tx_adr_i), .eth_dat_o(eth_tx_dat_o)
);

bdl_regs u_bdl (
	.lwb_clkp(lwb_clkp), .wb_rst_i(wb_rst_i),
	.lb_req_i(lb_req), .lb_sel_i(lbdl_sel), .lb_dat_o(lbdl_dat),
	.dma_sel_i(dbdl_sel), .dma_we_i(dbdl_we), .dma_adr_i(dma_req.adr[`DQ_BDL_AW-1:0]),
	.dma_dat_i(dma_req.dat), .dma_dat_o(dbdl_dat)
);

dma_port u_dma (
	.lwb_clkp(lwb_clkp), .wb_rst_i(wb_rst_i),
	.dma_stb_i(dma_stb_i), .dma_req_i(dma_req), .dma_ack_o(dma_ack_o), .dma_dat_o(dma_dat_o),
	.rxb_rd_o(drxb_rd), .txb_we_o(dtxb_we), .bdl_sel_o(dbdl_sel), .bdl_we_o(dbdl_we),
	.rxb_dat_i(drxb_dat), .bdl_dat_i(dbdl_dat)
);

endmodule

/* rtl/dma_port.sv */
/*
  local side of the DMA engine
  reads reach the receive buffer and BDL, writes the transmit buffer and BDL
  a write to the receive buffer or a read of the transmit buffer is acked
  and dropped, returning zero, as is any unmapped address
*/
`include "delqa_settings.svh"

module dma_port import delqa_pkg::*; (
	input  logic			lwb_clkp,	// bus clock
	input  logic			wb_rst_i,	// async reset
	input  logic			dma_stb_i,	// DMA strobe, held until ack
	input  dma_req_t		dma_req_i,	// address, data, direction
	output logic			dma_ack_o,	// registered ack
	output logic [`DQ_DATA_W-1:0]	dma_dat_o,	// read word, valid with ack
	output logic			rxb_rd_o,	// receive buffer read
	output logic			txb_we_o,	// transmit buffer write
	output logic			bdl_sel_o,	// BDL access
	output logic			bdl_we_o,	// BDL write
	input  logic [`DQ_DATA_W-1:0]	rxb_dat_i,	// receive buffer word
	input  logic [`DQ_DATA_W-1:0]	bdl_dat_i	// BDL word
);

localparam int RX_SH  = `DQ_RXBUF_AW + 1;
localparam int TX_SH  = `DQ_TXBUF_AW + 1;
localparam int BDL_SH = `DQ_BDL_AW + 1;

logic [`DQ_ADR_W-1:0]	lad;		// byte form of the local address
logic			req;		// unanswered request
region_e		region;		// decoded target
region_e		ret_q;		// source of the returned word

assign lad = {dma_req_i.adr, 1'b0};
assign req = dma_stb_i & ~dma_ack_o;

// same map the processor sees
always_comb begin
	if ((lad >> RX_SH) == (`DQ_RXBUF_BASE >> RX_SH))
		region = REG_RXBUF;
	else if ((lad >> TX_SH) == (`DQ_TXBUF_BASE >> TX_SH))
		region = REG_TXBUF;
	else if ((lad >> BDL_SH) == (`DQ_BDL_BASE >> BDL_SH))
		region = REG_BDL;
	else
		region = REG_NONE;
end

//******************************
// strobe steering
//******************************
assign rxb_rd_o  = req & (region == REG_RXBUF) & ~dma_req_i.we;	// read only
assign txb_we_o  = req & (region == REG_TXBUF) & dma_req_i.we;	// write only
assign bdl_sel_o = req & (region == REG_BDL);
assign bdl_we_o  = bdl_sel_o & dma_req_i.we;

always_ff @(posedge lwb_clkp or posedge wb_rst_i) begin
	if (wb_rst_i) begin
		dma_ack_o <= 1'b0;
		ret_q     <= REG_NONE;
	end else begin
		dma_ack_o <= req;
		if (req)
			ret_q <= dma_req_i.we ? REG_NONE : region;	// writes return zero
	end
end

always_comb begin
	case (ret_q)
		REG_RXBUF:	dma_dat_o = rxb_dat_i;
		REG_BDL:	dma_dat_o = bdl_dat_i;
		default:	dma_dat_o = '0;	// tx buffer reads land here
	endcase
end

endmodule

/* rtl/bdl_regs.sv */
/*
  eight buffer descriptor words, cleared by reset
  local bus writes honor byte selects, DMA writes whole words
  reads on both sides are registered, old value on a same-cycle write
*/
`include "delqa_settings.svh"

module bdl_regs import delqa_pkg::*; (
	input  logic			lwb_clkp,	// bus clock
	input  logic			wb_rst_i,	// async reset
	input  lb_req_t			lb_req_i,	// local-bus request
	input  logic			lb_sel_i,	// local-bus select
	output logic [`DQ_DATA_W-1:0]	lb_dat_o,	// local-bus read word
	input  logic			dma_sel_i,	// DMA select
	input  logic			dma_we_i,	// DMA write
	input  logic [`DQ_BDL_AW-1:0]	dma_adr_i,	// DMA register index
	input  logic [`DQ_DATA_W-1:0]	dma_dat_i,	// DMA write word
	output logic [`DQ_DATA_W-1:0]	dma_dat_o	// DMA read word
);

logic [`DQ_DATA_W-1:0]	bdl [0:(1 << `DQ_BDL_AW)-1];	// descriptor words
logic [`DQ_BDL_AW-1:0]	lb_idx;				// local-bus index

assign lb_idx = lb_req_i.adr[`DQ_BDL_AW-1:0];

always_ff @(posedge lwb_clkp or posedge wb_rst_i) begin
	if (wb_rst_i) begin
		for (int i = 0; i < (1 << `DQ_BDL_AW); i++)
			bdl[i] <= '0;
	end else begin
		if (lb_sel_i && lb_req_i.we) begin
			if (lb_req_i.sel[0])
				bdl[lb_idx][7:0] <= lb_req_i.dat[7:0];
			if (lb_req_i.sel[1])
				bdl[lb_idx][15:8] <= lb_req_i.dat[15:8];
		end
		if (dma_sel_i && dma_we_i)
			bdl[dma_adr_i] <= dma_dat_i;	// DMA last, wins a tie
	end
end

//******************************
// registered reads
//******************************
always_ff @(posedge lwb_clkp) begin
	if (lb_sel_i)
		lb_dat_o <= bdl[lb_idx];
	if (dma_sel_i && !dma_we_i)
		dma_dat_o <= bdl[dma_adr_i];
end

endmodule

/* rtl/tx_buffer.sv */
/*
  transmit buffer, 1024 words, synchronous read on both ports
  port A is the local bus, port B takes DMA writes or the Ethernet read
  the Ethernet read has no strobe, so a DMA write blocks it for that cycle
*/
`include "delqa_settings.svh"

module tx_buffer import delqa_pkg::*; (
	input  logic			lwb_clkp,	// bus clock
	input  lb_req_t			lb_req_i,	// local-bus request
	input  logic			lb_sel_i,	// local-bus select
	output logic [`DQ_DATA_W-1:0]	lb_dat_o,	// local-bus read word
	input  logic			dma_we_i,	// DMA write strobe
	input  logic [`DQ_TXBUF_AW-1:0]	dma_adr_i,	// DMA word address
	input  logic [`DQ_DATA_W-1:0]	dma_dat_i,	// DMA write word
	input  logic [`DQ_TXBUF_AW-1:0]	eth_adr_i,	// Ethernet read address
	output logic [`DQ_DATA_W-1:0]	eth_dat_o	// word to transmit, next cycle
);

logic [`DQ_DATA_W-1:0]		mem [0:(1 << `DQ_TXBUF_AW)-1];
logic [`DQ_TXBUF_AW-1:0]	lb_wa;

assign lb_wa = lb_req_i.adr[`DQ_TXBUF_AW-1:0];

always_ff @(posedge lwb_clkp) begin
	// port A, local bus with byte selects
	if (lb_sel_i) begin
		if (lb_req_i.we) begin
			if (lb_req_i.sel[0])
				mem[lb_wa][7:0] <= lb_req_i.dat[7:0];
			if (lb_req_i.sel[1])
				mem[lb_wa][15:8] <= lb_req_i.dat[15:8];
		end
		lb_dat_o <= mem[lb_wa];
	end
	// port B, DMA fill or Ethernet fetch
	if (dma_we_i)
		mem[dma_adr_i] <= dma_dat_i;
	else
		eth_dat_o <= mem[eth_adr_i];	// free-running fetch
end

// a fresh Ethernet address must find port B free of DMA writes
a_tx_portb: assert property (@(posedge lwb_clkp) $changed(eth_adr_i) |-> !dma_we_i)
	else $error("tx_buffer: DMA write collides with Ethernet read");

endmodule

/* rtl/rx_buffer.sv */
/*
  receive buffer, 2048 words, synchronous read on both ports
  port A is the local bus, port B takes Ethernet writes or DMA reads
  an Ethernet write and a DMA read must never share a cycle
*/
`include "delqa_settings.svh"

module rx_buffer import delqa_pkg::*; (
	input  logic			lwb_clkp,	// bus clock
	input  lb_req_t			lb_req_i,	// local-bus request
	input  logic			lb_sel_i,	// local-bus select
	output logic [`DQ_DATA_W-1:0]	lb_dat_o,	// local-bus read word
	input  logic			dma_rd_i,	// DMA read strobe
	input  logic [`DQ_RXBUF_AW-1:0]	dma_adr_i,	// DMA word address
	output logic [`DQ_DATA_W-1:0]	dma_dat_o,	// DMA read word
	input  logic			eth_we_i,	// Ethernet write strobe
	input  logic [`DQ_RXBUF_AW-1:0]	eth_adr_i,	// Ethernet word address
	input  logic [`DQ_DATA_W-1:0]	eth_dat_i	// received word
);

logic [`DQ_DATA_W-1:0]		mem [0:(1 << `DQ_RXBUF_AW)-1];	// buffer storage
logic [`DQ_RXBUF_AW-1:0]	lb_wa;				// local-bus word address

assign lb_wa = lb_req_i.adr[`DQ_RXBUF_AW-1:0];	// drop region bits

// both ports in one process, port B wins on a same-address write
always_ff @(posedge lwb_clkp) begin
	// port A, local bus
	if (lb_sel_i) begin
		if (lb_req_i.we) begin
			if (lb_req_i.sel[0])
				mem[lb_wa][7:0] <= lb_req_i.dat[7:0];	// low byte
			if (lb_req_i.sel[1])
				mem[lb_wa][15:8] <= lb_req_i.dat[15:8];	// high byte
		end
		lb_dat_o <= mem[lb_wa];	// old word on a write
	end
	// port B, Ethernet write has priority
	if (eth_we_i)
		mem[eth_adr_i] <= eth_dat_i;
	else if (dma_rd_i)
		dma_dat_o <= mem[dma_adr_i];
end

// DMA engine and receive side share port B
a_rx_portb: assert property (@(posedge lwb_clkp) !(eth_we_i && dma_rd_i))
	else $error("rx_buffer: Ethernet write collides with DMA read");

endmodule

/* rtl/lb_decoder.sv */
/*
  Wishbone slave front end of the core
  ack comes one cycle after cyc & stb, for every address, mapped or not
  unmapped reads return zero and unmapped writes are dropped
  master must drop stb for a cycle after ack
*/
`include "delqa_settings.svh"

module lb_decoder import delqa_pkg::*; (
	input  logic			lwb_clkp,	// bus clock
	input  logic			wb_rst_i,	// async reset
	input  logic			wb_cyc_i,	// bus cycle
	input  logic			wb_stb_i,	// strobe
	input  logic			wb_we_i,	// 1 - write
	input  logic [1:0]		wb_sel_i,	// byte selects
	input  logic [`DQ_ADR_W-1:0]	wb_adr_i,	// byte address
	input  logic [`DQ_DATA_W-1:0]	wb_dat_i,	// write data
	output logic			wb_ack_o,	// registered ack
	output logic [`DQ_DATA_W-1:0]	wb_dat_o,	// read data, valid with ack
	output lb_req_t			lb_req_o,	// request to targets
	output logic			rxb_sel_o,	// receive buffer select
	output logic			txb_sel_o,	// transmit buffer select
	output logic			bdl_sel_o,	// BDL select
	input  logic [`DQ_DATA_W-1:0]	rxb_dat_i,	// words back from targets
	input  logic [`DQ_DATA_W-1:0]	txb_dat_i,
	input  logic [`DQ_DATA_W-1:0]	bdl_dat_i
);

localparam int RX_SH  = `DQ_RXBUF_AW + 1;	// byte address bits inside each region
localparam int TX_SH  = `DQ_TXBUF_AW + 1;
localparam int BDL_SH = `DQ_BDL_AW + 1;

logic		req;		// new request, not yet answered
region_e	region;		// decoded target
region_e	region_q;	// target of the access being acked

assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

//******************************
// address decode
//******************************
always_comb begin
	if ((wb_adr_i >> RX_SH) == (`DQ_RXBUF_BASE >> RX_SH))
		region = REG_RXBUF;
	else if ((wb_adr_i >> TX_SH) == (`DQ_TXBUF_BASE >> TX_SH))
		region = REG_TXBUF;
	else if ((wb_adr_i >> BDL_SH) == (`DQ_BDL_BASE >> BDL_SH))
		region = REG_BDL;
	else
		region = REG_NONE;
end

assign rxb_sel_o = req & (region == REG_RXBUF);
assign txb_sel_o = req & (region == REG_TXBUF);
assign bdl_sel_o = req & (region == REG_BDL);

assign lb_req_o = '{adr: wb_adr_i[`DQ_ADR_W-1:1], dat: wb_dat_i, we: wb_we_i, sel: wb_sel_i};

always_ff @(posedge lwb_clkp or posedge wb_rst_i) begin
	if (wb_rst_i) begin
		wb_ack_o <= 1'b0;
		region_q <= REG_NONE;
	end else begin
		wb_ack_o <= req;		// one ack per request
		if (req)
			region_q <= region;	// steers the returned word
	end
end

// return mux, zero when nothing mapped
always_comb begin
	case (region_q)
		REG_RXBUF:	wb_dat_o = rxb_dat_i;
		REG_TXBUF:	wb_dat_o = txb_dat_i;
		REG_BDL:	wb_dat_o = bdl_dat_i;
		default:	wb_dat_o = '0;
	endcase
end

// a strobe still held after ack would be answered a second time
a_stb_drop: assert property (@(posedge lwb_clkp) disable iff (wb_rst_i)
	wb_ack_o |-> !(wb_cyc_i && wb_stb_i))
	else $error("lb_decoder: master kept stb high after ack");

endmodule

/* rtl/delqa_pkg.sv */
/*
  shared types of the core
  word addresses are the byte address without bit 0
*/
`include "delqa_settings.svh"

package delqa_pkg;

	// one local-bus request as seen by the targets
	typedef struct packed {
		logic [`DQ_ADR_W-2:0]	adr;	// word address
		logic [`DQ_DATA_W-1:0]	dat;	// write data
		logic			we;	// 1 - write
		logic [1:0]		sel;	// byte selects, bit 1 is high byte
	} lb_req_t;

	// one DMA-side request, always whole words
	typedef struct packed {
		logic [`DQ_ADR_W-2:0]	adr;	// word address, as dma_lad[15:1]
		logic [`DQ_DATA_W-1:0]	dat;	// write data
		logic			we;	// 1 - write into the core
	} dma_req_t;

	// decoded target of an access
	typedef enum logic [1:0] {
		REG_NONE,	// unmapped
		REG_RXBUF,	// receive buffer
		REG_TXBUF,	// transmit buffer
		REG_BDL		// descriptor registers
	} region_e;

endpackage

/* rtl/delqa_settings.svh */
/*
  widths, buffer depths and region bases of the DELQA shared-memory core
  bases are local-bus byte addresses, each region aligned to its own size
  byte select is two bits, so the data width stays at 16
*/
`ifndef DELQA_SETTINGS_SVH
`define DELQA_SETTINGS_SVH

//******************************
// bus widths
//******************************
`define DQ_DATA_W	16	// data bus width
`define DQ_ADR_W	16	// local-bus byte address width

//******************************
// buffer depths, as word address widths
//******************************
`define DQ_RXBUF_AW	11	// 2048 words of receive buffer
`define DQ_TXBUF_AW	10	// 1024 words of transmit buffer
`define DQ_BDL_AW	3	// eight descriptor words

//******************************
// region bases, octal byte addresses
//******************************
`define DQ_RXBUF_BASE	(16'o010000)	// 010000-017777
`define DQ_TXBUF_BASE	(16'o020000)	// 020000-023777
`define DQ_BDL_BASE	(16'o024000)	// 024000-024017

`endif
